/* upsize_config.svh */
`ifndef UPSIZE_CONFIG_SVH
`define UPSIZE_CONFIG_SVH

// ----------------------------------------
// Bus geometry
// ----------------------------------------

// Byte address width on both sides
`define UPS_ADDR_WIDTH 32

// Shared by both sides, so IDs pass through unchanged
`define UPS_ID_WIDTH 4

// The wide side must be strictly wider than the narrow side
`define UPS_NARROW_DW 32
`define UPS_WIDE_DW 64

// Cache attribute bit that allows a burst to be re-encoded
`define UPS_CACHE_MODIFIABLE 1

`endif

/* upsize_pkg.sv */
`include "upsize_config.svh"

package upsize_pkg;

  // ----------------------------------------
  // Scalar types
  // ----------------------------------------

  typedef logic [`UPS_ADDR_WIDTH-1:0] addr_t;
  typedef logic [`UPS_ID_WIDTH-1:0]   id_t;
  typedef logic [7:0]                 len_t;
  typedef logic [2:0]                 size_t;
  typedef logic [1:0]                 resp_t;
  typedef logic [3:0]                 cache_t;

  typedef enum logic [1:0] {
    BURST_FIXED = 2'b00,
    BURST_INCR  = 2'b01,
    BURST_WRAP  = 2'b10
  } burst_t;

  typedef logic [`UPS_NARROW_DW-1:0]   narrow_data_t;
  typedef logic [`UPS_NARROW_DW/8-1:0] narrow_strb_t;
  typedef logic [`UPS_WIDE_DW-1:0]     wide_data_t;
  typedef logic [`UPS_WIDE_DW/8-1:0]   wide_strb_t;

  // ----------------------------------------
  // Channel payloads
  // ----------------------------------------

  // Shared by AR and AW
  typedef struct packed {
    id_t    id;
    addr_t  addr;
    len_t   len;
    size_t  size;
    burst_t burst;
    cache_t cache;
  } ax_req_t;

  typedef struct packed {
    narrow_data_t data;
    narrow_strb_t strb;
    logic         last;
  } narrow_w_t;

  typedef struct packed {
    wide_data_t data;
    wide_strb_t strb;
    logic       last;
  } wide_w_t;

  typedef struct packed {
    id_t          id;
    narrow_data_t data;
    resp_t        resp;
    logic         last;
  } narrow_r_t;

  typedef struct packed {
    id_t        id;
    wide_data_t data;
    resp_t      resp;
    logic       last;
  } wide_r_t;

  typedef struct packed {
    id_t   id;
    resp_t resp;
  } b_rsp_t;

  // Per-path burst handling mode
  typedef enum logic [1:0] {
    IDLE,
    PASSTHROUGH,
    INCR_UPSIZE
  } upsize_mode_e;

endpackage

/* upsize_burst_calc.sv */
`include "upsize_config.svh"

module upsize_burst_calc
  import upsize_pkg::*;
(
  input  ax_req_t      req,
  output upsize_mode_e mode,
  output len_t         out_len,
  output size_t        out_size
);

  localparam int unsigned WIDE_BYTES = `UPS_WIDE_DW / 8;
  localparam int unsigned WIDE_OFF_W = $clog2(WIDE_BYTES);

  addr_t size_mask;
  addr_t last_beat_addr;
  addr_t first_word;
  addr_t last_word;
  logic  upsize_ok;

  // Address of the final narrow beat, aligned to the beat size
  assign size_mask      = (addr_t'(1) << req.size) - addr_t'(1);
  assign last_beat_addr = (req.addr & ~size_mask) + (addr_t'(req.len) << req.size);

  // Wide word indices of the first and last beat
  assign first_word = req.addr >> WIDE_OFF_W;
  assign last_word  = last_beat_addr >> WIDE_OFF_W;

  assign upsize_ok = (req.burst == BURST_INCR) && req.cache[`UPS_CACHE_MODIFIABLE];

  always_comb begin
    if (upsize_ok) begin
      // One wide beat per word touched by the burst
      mode     = INCR_UPSIZE;
      out_len  = len_t'(last_word - first_word);
      out_size = size_t'(WIDE_OFF_W);
    end else begin
      mode     = PASSTHROUGH;
      out_len  = req.len;
      out_size = req.size;
    end
  end

endmodule

/* upsize_read.sv */
`include "upsize_config.svh"

module upsize_read
  import upsize_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  ax_req_t   slv_ar,
  input  logic      slv_ar_valid,
  output logic      slv_ar_ready,
  output narrow_r_t slv_r,
  output logic      slv_r_valid,
  input  logic      slv_r_ready,
  output ax_req_t   mst_ar,
  output logic      mst_ar_valid,
  input  logic      mst_ar_ready,
  input  wide_r_t   mst_r,
  input  logic      mst_r_valid,
  output logic      mst_r_ready
);

  localparam int unsigned NARROW_BYTES = `UPS_NARROW_DW / 8;
  localparam int unsigned NARROW_OFF_W = $clog2(NARROW_BYTES);
  localparam int unsigned WIDE_OFF_W   = $clog2(`UPS_WIDE_DW / 8);

  upsize_mode_e mode_q, mode_d, calc_mode;
  len_t         calc_len;
  size_t        calc_size;

  ax_req_t ar_q, ar_d;
  logic    ar_valid_q, ar_valid_d;
  addr_t   addr_q, addr_d;
  size_t   size_q, size_d;
  len_t    len_q, len_d;
  wide_r_t word_q, word_d;
  logic    full_q, full_d;

  addr_t                        size_mask;
  addr_t                        addr_next;
  logic                         word_cross;
  logic                         beat_fire;
  logic [NARROW_OFF_W-1:0]      lane_off;
  int unsigned                  lane_base;
  int unsigned                  beat_bytes;

  upsize_burst_calc i_calc (
    .req      (slv_ar),
    .mode     (calc_mode),
    .out_len  (calc_len),
    .out_size (calc_size)
  );

  // ----------------------------------------
  // Narrow beat address
  // ----------------------------------------

  assign size_mask  = (addr_t'(1) << size_q) - addr_t'(1);
  assign addr_next  = (addr_q & ~size_mask) + (addr_t'(1) << size_q);
  assign word_cross = addr_next[`UPS_ADDR_WIDTH-1:WIDE_OFF_W] !=
                      addr_q[`UPS_ADDR_WIDTH-1:WIDE_OFF_W];

  assign lane_off   = addr_q[NARROW_OFF_W-1:0];
  assign lane_base  = NARROW_BYTES * addr_q[WIDE_OFF_W-1:NARROW_OFF_W];
  assign beat_bytes = 1 << size_q;

  // ----------------------------------------
  // Outputs
  // ----------------------------------------

  assign slv_ar_ready = (mode_q == IDLE);
  assign mst_ar       = ar_q;
  assign mst_ar_valid = ar_valid_q;
  assign mst_r_ready  = (mode_q != IDLE) && !ar_valid_q && !full_q;
  assign slv_r_valid  = full_q;
  assign beat_fire    = full_q && slv_r_ready;

  // Serialize the active bytes of the held word into the narrow lanes
  always_comb begin
    slv_r      = '0;
    slv_r.id   = word_q.id;
    slv_r.resp = word_q.resp;
    slv_r.last = word_q.last && (len_q == '0);
    for (int unsigned n = 0; n < NARROW_BYTES; n++) begin
      if ((n >= lane_off) && ((n - lane_off) < beat_bytes)) begin
        slv_r.data[8*n +: 8] = word_q.data[8*(lane_base + n) +: 8];
      end
    end
  end

  // ----------------------------------------
  // Next state
  // ----------------------------------------

  always_comb begin
    mode_d     = mode_q;
    ar_d       = ar_q;
    ar_valid_d = ar_valid_q;
    addr_d     = addr_q;
    size_d     = size_q;
    len_d      = len_q;
    word_d     = word_q;
    full_d     = full_q;

    if (mst_ar_valid && mst_ar_ready) begin
      ar_valid_d = 1'b0;
    end

    if (mst_r_valid && mst_r_ready) begin
      word_d = mst_r;
      full_d = 1'b1;
    end

    if (beat_fire) begin
      len_d  = len_q - 1'b1;
      addr_d = addr_next;
      // Upsized words hold several narrow beats
      if ((mode_q == PASSTHROUGH) || word_cross || (len_q == '0)) begin
        full_d = 1'b0;
      end
      if (len_q == '0) begin
        mode_d = IDLE;
      end
    end

    if (slv_ar_valid && slv_ar_ready) begin
      mode_d     = calc_mode;
      ar_d       = slv_ar;
      ar_d.len   = calc_len;
      ar_d.size  = calc_size;
      ar_valid_d = 1'b1;
      addr_d     = slv_ar.addr;
      size_d     = slv_ar.size;
      len_d      = slv_ar.len;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mode_q     <= IDLE;
      ar_valid_q <= 1'b0;
      full_q     <= 1'b0;
      len_q      <= '0;
    end else begin
      mode_q     <= mode_d;
      ar_valid_q <= ar_valid_d;
      full_q     <= full_d;
      len_q      <= len_d;
    end
  end

  always_ff @(posedge clk_i) begin
    ar_q   <= ar_d;
    addr_q <= addr_d;
    size_q <= size_d;
    word_q <= word_d;
  end

endmodule

/* upsize_write.sv */
`include "upsize_config.svh"

module upsize_write
  import upsize_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  ax_req_t   slv_aw,
  input  logic      slv_aw_valid,
  output logic      slv_aw_ready,
  input  narrow_w_t slv_w,
  input  logic      slv_w_valid,
  output logic      slv_w_ready,
  output ax_req_t   mst_aw,
  output logic      mst_aw_valid,
  input  logic      mst_aw_ready,
  output wide_w_t   mst_w,
  output logic      mst_w_valid,
  input  logic      mst_w_ready
);

  localparam int unsigned NARROW_BYTES = `UPS_NARROW_DW / 8;
  localparam int unsigned NARROW_OFF_W = $clog2(NARROW_BYTES);
  localparam int unsigned WIDE_OFF_W   = $clog2(`UPS_WIDE_DW / 8);

  upsize_mode_e mode_q, mode_d, calc_mode;
  len_t         calc_len;
  size_t        calc_size;

  ax_req_t aw_q, aw_d;
  logic    aw_valid_q, aw_valid_d;
  addr_t   addr_q, addr_d;
  size_t   size_q, size_d;
  len_t    len_q, len_d;
  wide_w_t w_q, w_d;
  logic    w_valid_q, w_valid_d;

  addr_t                   size_mask;
  addr_t                   addr_next;
  logic                    word_cross;
  logic                    w_fire;
  logic                    final_pending;
  logic [NARROW_OFF_W-1:0] lane_off;
  int unsigned             lane_base;
  int unsigned             beat_bytes;

  upsize_burst_calc i_calc (
    .req      (slv_aw),
    .mode     (calc_mode),
    .out_len  (calc_len),
    .out_size (calc_size)
  );

  // ----------------------------------------
  // Narrow beat address
  // ----------------------------------------

  assign size_mask  = (addr_t'(1) << size_q) - addr_t'(1);
  assign addr_next  = (addr_q & ~size_mask) + (addr_t'(1) << size_q);
  assign word_cross = addr_next[`UPS_ADDR_WIDTH-1:WIDE_OFF_W] !=
                      addr_q[`UPS_ADDR_WIDTH-1:WIDE_OFF_W];

  assign lane_off   = addr_q[NARROW_OFF_W-1:0];
  assign lane_base  = NARROW_BYTES * addr_q[WIDE_OFF_W-1:NARROW_OFF_W];
  assign beat_bytes = 1 << size_q;

  // ----------------------------------------
  // Outputs
  // ----------------------------------------

  assign slv_aw_ready = (mode_q == IDLE);
  assign mst_aw       = aw_q;
  assign mst_aw_valid = aw_valid_q;
  assign mst_w        = w_q;
  assign mst_w_valid  = w_valid_q;
  assign w_fire       = w_valid_q && mst_w_ready;

  // No more narrow beats once the final word is waiting
  assign final_pending = w_valid_q && w_q.last;

  // Data only after AW went out, and only if the word register frees up
  assign slv_w_ready = (mode_q != IDLE) && !aw_valid_q && !final_pending &&
                       (!w_valid_q || mst_w_ready);

  // ----------------------------------------
  // Next state
  // ----------------------------------------

  always_comb begin
    mode_d     = mode_q;
    aw_d       = aw_q;
    aw_valid_d = aw_valid_q;
    addr_d     = addr_q;
    size_d     = size_q;
    len_d      = len_q;
    w_d        = w_q;
    w_valid_d  = w_valid_q;

    if (mst_aw_valid && mst_aw_ready) begin
      aw_valid_d = 1'b0;
    end

    // Sent word frees the register for the next merge
    if (w_fire) begin
      w_d       = '0;
      w_valid_d = 1'b0;
      if (w_q.last) begin
        mode_d = IDLE;
      end
    end

    if (slv_w_valid && slv_w_ready) begin
      // Steer the active narrow bytes into their wide lanes
      for (int unsigned n = 0; n < NARROW_BYTES; n++) begin
        if ((n >= lane_off) && ((n - lane_off) < beat_bytes)) begin
          w_d.data[8*(lane_base + n) +: 8] = slv_w.data[8*n +: 8];
          w_d.strb[lane_base + n]          = slv_w.strb[n];
        end
      end
      w_d.last = (len_q == '0);
      len_d    = len_q - 1'b1;
      addr_d   = addr_next;
      if ((mode_q == PASSTHROUGH) || word_cross || (len_q == '0)) begin
        w_valid_d = 1'b1;
      end
    end

    if (slv_aw_valid && slv_aw_ready) begin
      mode_d     = calc_mode;
      aw_d       = slv_aw;
      aw_d.len   = calc_len;
      aw_d.size  = calc_size;
      aw_valid_d = 1'b1;
      addr_d     = slv_aw.addr;
      size_d     = slv_aw.size;
      len_d      = slv_aw.len;
      w_d        = '0;
      w_valid_d  = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mode_q     <= IDLE;
      aw_valid_q <= 1'b0;
      w_valid_q  <= 1'b0;
      len_q      <= '0;
    end else begin
      mode_q     <= mode_d;
      aw_valid_q <= aw_valid_d;
      w_valid_q  <= w_valid_d;
      len_q      <= len_d;
    end
  end

  always_ff @(posedge clk_i) begin
    aw_q   <= aw_d;
    addr_q <= addr_d;
    size_q <= size_d;
    w_q    <= w_d;
  end

endmodule

/* axi_upsize_top.sv */
module axi_upsize_top
  import upsize_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,

  // Narrow slave side
  input  ax_req_t   slv_ar,
  input  logic      slv_ar_valid,
  output logic      slv_ar_ready,
  output narrow_r_t slv_r,
  output logic      slv_r_valid,
  input  logic      slv_r_ready,
  input  ax_req_t   slv_aw,
  input  logic      slv_aw_valid,
  output logic      slv_aw_ready,
  input  narrow_w_t slv_w,
  input  logic      slv_w_valid,
  output logic      slv_w_ready,
  output b_rsp_t    slv_b,
  output logic      slv_b_valid,
  input  logic      slv_b_ready,

  // Wide master side
  output ax_req_t   mst_ar,
  output logic      mst_ar_valid,
  input  logic      mst_ar_ready,
  input  wide_r_t   mst_r,
  input  logic      mst_r_valid,
  output logic      mst_r_ready,
  output ax_req_t   mst_aw,
  output logic      mst_aw_valid,
  input  logic      mst_aw_ready,
  output wide_w_t   mst_w,
  output logic      mst_w_valid,
  input  logic      mst_w_ready,
  input  b_rsp_t    mst_b,
  input  logic      mst_b_valid,
  output logic      mst_b_ready
);

  upsize_read i_read (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .slv_ar       (slv_ar),
    .slv_ar_valid (slv_ar_valid),
    .slv_ar_ready (slv_ar_ready),
    .slv_r        (slv_r),
    .slv_r_valid  (slv_r_valid),
    .slv_r_ready  (slv_r_ready),
    .mst_ar       (mst_ar),
    .mst_ar_valid (mst_ar_valid),
    .mst_ar_ready (mst_ar_ready),
    .mst_r        (mst_r),
    .mst_r_valid  (mst_r_valid),
    .mst_r_ready  (mst_r_ready)
  );

  upsize_write i_write (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .slv_aw       (slv_aw),
    .slv_aw_valid (slv_aw_valid),
    .slv_aw_ready (slv_aw_ready),
    .slv_w        (slv_w),
    .slv_w_valid  (slv_w_valid),
    .slv_w_ready  (slv_w_ready),
    .mst_aw       (mst_aw),
    .mst_aw_valid (mst_aw_valid),
    .mst_aw_ready (mst_aw_ready),
    .mst_w        (mst_w),
    .mst_w_valid  (mst_w_valid),
    .mst_w_ready  (mst_w_ready)
  );

  // B needs no width change, so it passes straight through
  assign slv_b       = mst_b;
  assign slv_b_valid = mst_b_valid;
  assign mst_b_ready = slv_b_ready;

endmodule

/* tb_upsize.sv */
`include "upsize_config.svh"

module tb_upsize
  import upsize_pkg::*;
;
  timeunit 1ns;
  timeprecision 100ps;

  // Longest test is well under a few hundred cycles
  localparam int unsigned WATCHDOG_CYCLES = 2000;

  logic clk_i = 1'b0;
  logic rst_ni = 1'b0;

  ax_req_t   slv_ar = '0;
  logic      slv_ar_valid = 1'b0;
  logic      slv_ar_ready;
  narrow_r_t slv_r;
  logic      slv_r_valid;
  logic      slv_r_ready = 1'b0;
  ax_req_t   slv_aw = '0;
  logic      slv_aw_valid = 1'b0;
  logic      slv_aw_ready;
  narrow_w_t slv_w = '0;
  logic      slv_w_valid = 1'b0;
  logic      slv_w_ready;
  b_rsp_t    slv_b;
  logic      slv_b_valid;
  logic      slv_b_ready = 1'b1;

  ax_req_t mst_ar;
  logic    mst_ar_valid;
  logic    mst_ar_ready = 1'b1;
  wide_r_t mst_r = '0;
  logic    mst_r_valid = 1'b0;
  logic    mst_r_ready;
  ax_req_t mst_aw;
  logic    mst_aw_valid;
  logic    mst_aw_ready = 1'b1;
  wide_w_t mst_w;
  logic    mst_w_valid;
  logic    mst_w_ready = 1'b1;
  b_rsp_t  mst_b = '0;
  logic    mst_b_valid = 1'b0;
  logic    mst_b_ready;

  wide_data_t  mem [256];
  wide_data_t  exp_mem [256];
  ax_req_t     ar_log [$];
  ax_req_t     aw_log [$];
  wide_w_t     w_log [$];
  logic [31:0] lcg_state = 32'hd0b7;
  int unsigned error_count = 0;
  logic        w_bp = 1'b0;

  addr_t rd_addr;
  size_t rd_size;
  len_t  rd_left;
  addr_t wr_addr;
  size_t wr_size;
  id_t   wr_id;

  axi_upsize_top i_dut (.*);

  initial begin
    forever #2 clk_i = ~clk_i;
  end

  function automatic logic [31:0] lcg();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // ----------------------------------------
  // Wide memory slave model
  // ----------------------------------------

  always @(posedge clk_i) begin : read_model
    addr_t na;
    if (!rst_ni) begin
      mst_r_valid <= 1'b0;
    end else begin
      if (mst_r_valid && mst_r_ready) begin
        if (mst_r.last) begin
          mst_r_valid <= 1'b0;
        end else begin
          na = rd_addr + (addr_t'(1) << rd_size);
          rd_addr     <= na;
          rd_left     <= rd_left - 1'b1;
          mst_r.data  <= mem[na[10:3]];
          mst_r.last  <= (rd_left == 8'd1);
        end
      end
      if (mst_ar_valid && mst_ar_ready) begin
        ar_log.push_back(mst_ar);
        na = mst_ar.addr & ~((addr_t'(1) << mst_ar.size) - addr_t'(1));
        rd_addr     <= na;
        rd_size     <= mst_ar.size;
        rd_left     <= mst_ar.len;
        mst_r.id    <= mst_ar.id;
        mst_r.data  <= mem[na[10:3]];
        mst_r.resp  <= 2'b00;
        mst_r.last  <= (mst_ar.len == '0);
        mst_r_valid <= 1'b1;
      end
    end
  end

  always @(posedge clk_i) begin : write_model
    logic [31:0] rnd;
    if (!rst_ni) begin
      mst_w_ready <= 1'b1;
      mst_b_valid <= 1'b0;
    end else begin
      if (w_bp) begin
        rnd = lcg();
        mst_w_ready <= rnd[16];
      end else begin
        mst_w_ready <= 1'b1;
      end
      if (mst_b_valid && mst_b_ready) begin
        mst_b_valid <= 1'b0;
      end
      if (mst_w_valid && mst_w_ready) begin
        w_log.push_back(mst_w);
        for (int b = 0; b < 8; b++) begin
          if (mst_w.strb[b]) begin
            mem[wr_addr[10:3]][8*b +: 8] <= mst_w.data[8*b +: 8];
          end
        end
        wr_addr <= wr_addr + (addr_t'(1) << wr_size);
        if (mst_w.last) begin
          mst_b_valid <= 1'b1;
          mst_b.id    <= wr_id;
          mst_b.resp  <= 2'b00;
        end
      end
      if (mst_aw_valid && mst_aw_ready) begin
        aw_log.push_back(mst_aw);
        wr_addr <= mst_aw.addr & ~((addr_t'(1) << mst_aw.size) - addr_t'(1));
        wr_size <= mst_aw.size;
        wr_id   <= mst_aw.id;
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("Watchdog expired after %0d cycles, a handshake never completed",
             WATCHDOG_CYCLES);
    $display("Result: FAILED");
    $finish;
  end

  // ----------------------------------------
  // Compare tasks
  // ----------------------------------------

  task automatic check_r(input narrow_r_t got, input narrow_r_t exp, input string what);
    if (got !== exp) begin
      error_count++;
      $display("Fail %0t: %s R got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_ax(input ax_req_t got, input ax_req_t exp, input string what);
    if (got !== exp) begin
      error_count++;
      $display("Fail %0t: %s request got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_wide(input wide_data_t got, input wide_data_t exp, input string what);
    if (got !== exp) begin
      error_count++;
      $display("Fail %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_strb(input wide_strb_t got, input wide_strb_t exp, input string what);
    if (got !== exp) begin
      error_count++;
      $display("Fail %0t: %s strobe got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_b(input b_rsp_t got, input b_rsp_t exp, input string what);
    if (got !== exp) begin
      error_count++;
      $display("Fail %0t: %s B got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      error_count++;
      $display("Fail %0t: %s is %b expected %b", $time, what, got, exp);
    end
  endtask

  // Master-side request by the upsizing rule for size-aligned starts
  function automatic ax_req_t expected_ax(input ax_req_t req);
    ax_req_t e;
    addr_t   last_a;
    e = req;
    if ((req.burst == BURST_INCR) && req.cache[`UPS_CACHE_MODIFIABLE]) begin
      last_a = req.addr + (addr_t'(req.len) << req.size);
      e.len  = len_t'((last_a >> 3) - (req.addr >> 3));
      e.size = 3'd3;
    end
    return e;
  endfunction

  function automatic ax_req_t make_req(input id_t id, input addr_t addr, input len_t len,
                                       input burst_t burst, input cache_t cache);
    ax_req_t r;
    r.id    = id;
    r.addr  = addr;
    r.len   = len;
    r.size  = 3'd2;
    r.burst = burst;
    r.cache = cache;
    return r;
  endfunction

  // ----------------------------------------
  // Drivers
  // ----------------------------------------

  task automatic run_read(input ax_req_t req, input logic bp, input string what);
    narrow_r_t   exp;
    addr_t       a;
    logic [31:0] rnd;
    int unsigned beats;
    @(posedge clk_i);
    slv_ar       <= req;
    slv_ar_valid <= 1'b1;
    @(negedge clk_i);
    while (!slv_ar_ready) @(negedge clk_i);
    @(posedge clk_i);
    slv_ar_valid <= 1'b0;
    beats = 0;
    while (beats <= req.len) begin
      @(posedge clk_i);
      rnd = lcg();
      slv_r_ready <= bp ? rnd[16] : 1'b1;
      @(negedge clk_i);
      if (slv_r_valid && slv_r_ready) begin
        a        = req.addr + addr_t'(4 * beats);
        exp.id   = req.id;
        exp.data = mem[a[10:3]][32*a[2] +: 32];
        exp.resp = 2'b00;
        exp.last = (beats == req.len);
        check_r(slv_r, exp, what);
        beats++;
      end
    end
    @(posedge clk_i);
    slv_r_ready <= 1'b0;
    check_ax(ar_log.pop_front(), expected_ax(req), what);
  endtask

  task automatic run_write(input ax_req_t req, input logic bp, input string what);
    narrow_w_t   beats [$];
    narrow_w_t   beat;
    addr_t       a;
    logic [31:0] rnd;
    b_rsp_t      exp_b;
    w_log.delete();
    for (int i = 0; i <= req.len; i++) begin
      beat.data = lcg();
      rnd       = lcg();
      beat.strb = (req.burst == BURST_FIXED) ? 4'hf : rnd[19:16];
      beat.last = (i == req.len);
      beats.push_back(beat);
    end
    w_bp <= bp;
    @(posedge clk_i);
    slv_aw       <= req;
    slv_aw_valid <= 1'b1;
    @(negedge clk_i);
    while (!slv_aw_ready) @(negedge clk_i);
    @(posedge clk_i);
    slv_aw_valid <= 1'b0;
    foreach (beats[i]) begin
      slv_w       <= beats[i];
      slv_w_valid <= 1'b1;
      @(negedge clk_i);
      while (!slv_w_ready) @(negedge clk_i);
      @(posedge clk_i);
    end
    slv_w_valid <= 1'b0;
    @(negedge clk_i);
    while (!slv_b_valid) @(negedge clk_i);
    exp_b.id   = req.id;
    exp_b.resp = 2'b00;
    check_b(slv_b, exp_b, what);
    check_b(slv_b, mst_b, {what, " passthrough"});
    @(posedge clk_i);
    w_bp <= 1'b0;
    check_ax(aw_log.pop_front(), expected_ax(req), what);
    foreach (beats[i]) begin
      a = req.addr + addr_t'(4 * i);
      for (int b = 0; b < 4; b++) begin
        if (beats[i].strb[b]) begin
          exp_mem[a[10:3]][8*(4*a[2] + b) +: 8] = beats[i].data[8*b +: 8];
        end
      end
      // One wide beat per narrow beat with the strobe in the addressed half
      if (req.burst == BURST_FIXED) begin
        check_strb(w_log[i].strb, a[2] ? 8'hf0 : 8'h0f, what);
        check_wide(w_log[i].data[32*a[2] +: 32], beats[i].data, {what, " lane data"});
      end
    end
    for (int w = 0; w < 256; w++) begin
      check_wide(mem[w], exp_mem[w], $sformatf("%s memory word %0d", what, w));
    end
  endtask

  // ----------------------------------------
  // Directed tests
  // ----------------------------------------

  task automatic test_reset_state();
    @(negedge clk_i);
    check_bit(mst_ar_valid, 1'b0, "mst_ar_valid after reset");
    check_bit(mst_aw_valid, 1'b0, "mst_aw_valid after reset");
    check_bit(mst_w_valid, 1'b0, "mst_w_valid after reset");
    check_bit(slv_r_valid, 1'b0, "slv_r_valid after reset");
    check_bit(slv_b_valid, 1'b0, "slv_b_valid after reset");
    check_bit(slv_ar_ready, 1'b1, "slv_ar_ready after reset");
    check_bit(slv_aw_ready, 1'b1, "slv_aw_ready after reset");
    // B ready goes back to the memory side unchanged
    @(posedge clk_i);
    slv_b_ready <= 1'b0;
    @(negedge clk_i);
    check_bit(mst_b_ready, 1'b0, "mst_b_ready with slv_b_ready low");
    @(posedge clk_i);
    slv_b_ready <= 1'b1;
    @(negedge clk_i);
    check_bit(mst_b_ready, 1'b1, "mst_b_ready with slv_b_ready high");
  endtask

  task automatic test_passthrough_read();
    run_read(make_req(4'h1, 32'h20, 8'd3, BURST_FIXED, 4'h2), 1'b0, "fixed read");
    run_read(make_req(4'h2, 32'h44, 8'd4, BURST_INCR, 4'h0), 1'b0, "incr read");
  endtask

  task automatic test_upsized_read(input logic bp);
    run_read(make_req(4'h3, 32'h0c, 8'd5, BURST_INCR, 4'h2), bp, "upsized read");
  endtask

  task automatic test_upsized_write(input addr_t addr, input logic bp);
    run_write(make_req(4'h5, addr, 8'd5, BURST_INCR, 4'h2), bp, "upsized write");
  endtask

  task automatic test_passthrough_write();
    run_write(make_req(4'h6, 32'h80, 8'd3, BURST_FIXED, 4'h0), 1'b0, "fixed write");
  endtask

  initial begin
    // Fill pattern mixes the word index into the random data
    for (int i = 0; i < 256; i++) begin
      mem[i]     = {lcg() ^ 32'(i), lcg()};
      exp_mem[i] = mem[i];
    end
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;
    test_reset_state();
    test_passthrough_read();
    test_upsized_read(1'b0);
    test_upsized_write(32'h4c, 1'b0);
    test_passthrough_write();
    test_upsized_read(1'b1);
    test_upsized_write(32'hcc, 1'b1);
    repeat (5) @(posedge clk_i);
    $display("Checks finished with %0d errors", error_count);
    if (error_count == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

/* all.f */
+incdir+.
upsize_pkg.sv
upsize_burst_calc.sv
upsize_read.sv
upsize_write.sv
axi_upsize_top.sv
tb_upsize.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_upsize
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
